//--- hw/npc_pkg.sv
`default_nettype none

package npc_pkg;

    // basic widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  imem_addr_t;
    typedef logic [2:0]  alu_op_t;

    // alu operation codes, every value of alu_op_t is used
    localparam alu_op_t ALU_NOP    = 3'd0;
    localparam alu_op_t ALU_LUI    = 3'd1;
    localparam alu_op_t ALU_AUIPC  = 3'd2;
    localparam alu_op_t ALU_JAL    = 3'd3;
    localparam alu_op_t ALU_JALR   = 3'd4;
    localparam alu_op_t ALU_ADDI   = 3'd5;
    localparam alu_op_t ALU_ADD    = 3'd6;
    localparam alu_op_t ALU_EBREAK = 3'd7;

    // start of the program window
    localparam word_t RESET_PC = 32'h8000_0000;

    // instruction memory size in words
    localparam int IMEM_DEPTH = 64;

    // major opcodes, instr[6:0]
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // ebreak is matched on the whole word
    localparam word_t INST_EBREAK = 32'h0010_0073;

endpackage

`default_nettype wire

//--- hw/instr_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module instr_fetch import npc_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       load_en,
    input  imem_addr_t load_addr,
    input  word_t      load_data,
    input  logic       run,
    input  word_t      next_pc,
    input  alu_op_t    alu_op,
    output word_t      pc,
    output word_t      instr,
    output logic       halted,
    output logic       advance
);

    // program storage behind the load port
    word_t imem [IMEM_DEPTH];

    // word index into imem
    // pc wraps inside the 64 word window
    imem_addr_t fetch_idx;

    // ebreak seen in the retiring slot
    logic is_ebreak;

    assign fetch_idx = pc[7:2];
    assign is_ebreak = (alu_op == ALU_EBREAK);

    // one instruction retires per clock while running
    assign advance = run && !halted;

    // new word reaches fetch after the edge
    always_ff @(posedge clk) begin
        if (load_en) begin
            imem[load_addr] <= load_data;
        end
    end

    // async read for single cycle fetch
    assign instr = imem[fetch_idx];

    // pc and halt flag
    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= RESET_PC;
            halted <= 1'b0;
        end else if (advance) begin
            if (is_ebreak) begin
                // pc stays on the ebreak
                halted <= 1'b1;
            end else begin
                pc <= next_pc;
            end
        end
    end

    // program loads only while stopped
    load_while_stopped: assert property (
        @(posedge clk) disable iff (reset)
        load_en |-> !run
    );

endmodule

`default_nettype wire

//--- hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import npc_pkg::*; (
    input  logic      clk,
    input  logic      advance,
    input  logic      wen,
    input  reg_addr_t waddr,
    input  word_t     wdata,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output word_t     rdata1,
    output word_t     rdata2
);

    // architectural registers, entry 0 never written
    word_t regs [32];

    // write qualified by retire, x0 writes dropped
    logic do_write;

    assign do_write = advance && wen && (waddr != '0);

    always_ff @(posedge clk) begin
        if (do_write) begin
            regs[waddr] <= wdata;
        end
    end

    // two async read ports
    // x0 reads as zero regardless of array contents
    always_comb begin
        if (raddr1 == '0) begin
            rdata1 = '0;
        end else begin
            rdata1 = regs[raddr1];
        end
        if (raddr2 == '0) begin
            rdata2 = '0;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

`default_nettype wire

//--- hw/inst_decode.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decode import npc_pkg::*; (
    input  word_t     instr,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output reg_addr_t rd,
    output word_t     imm,
    output alu_op_t   alu_op,
    output logic      reg_wen
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    // immediates per format, all sign extended
    word_t imm_i;
    word_t imm_u;
    word_t imm_j;

    // fixed field positions
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'h000};
    // j format, bit 0 implied zero
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    // opcode and funct fields to one operation
    always_comb begin
        alu_op = ALU_NOP;
        imm    = imm_i;
        if (instr == INST_EBREAK) begin
            alu_op = ALU_EBREAK;
        end else begin
            case (opcode)
                OPC_LUI: begin
                    alu_op = ALU_LUI;
                    imm    = imm_u;
                end
                OPC_AUIPC: begin
                    alu_op = ALU_AUIPC;
                    imm    = imm_u;
                end
                OPC_JAL: begin
                    alu_op = ALU_JAL;
                    imm    = imm_j;
                end
                // jalr and addi need funct3 zero
                OPC_JALR: begin
                    if (funct3 == 3'b000) alu_op = ALU_JALR;
                end
                OPC_OP_IMM: begin
                    if (funct3 == 3'b000) alu_op = ALU_ADDI;
                end
                OPC_OP: begin
                    if (funct3 == 3'b000 && funct7 == 7'b0000000) alu_op = ALU_ADD;
                end
                // anything else retires as a no-op
                default: alu_op = ALU_NOP;
            endcase
        end
    end

    // no write for no-op and ebreak
    assign reg_wen = !((alu_op == ALU_NOP) || (alu_op == ALU_EBREAK));

    // decoded op must be a known code, X here would corrupt regfile and pc
    always_comb begin
        op_defined: assert #0 (alu_op inside {ALU_NOP, ALU_LUI, ALU_AUIPC, ALU_JAL,
                                              ALU_JALR, ALU_ADDI, ALU_ADD, ALU_EBREAK});
    end

endmodule

`default_nettype wire

//--- hw/exec_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exec_alu import npc_pkg::*; (
    input  alu_op_t alu_op,
    input  word_t   pc,
    input  word_t   imm,
    input  word_t   src1,
    input  word_t   src2,
    output word_t   result,
    output word_t   next_pc
);

    // shared adders, all wrap at 32 bits
    word_t pc_plus_4;
    word_t pc_plus_imm;
    word_t src1_plus_imm;

    assign pc_plus_4     = pc + 32'd4;
    assign pc_plus_imm   = pc + imm;
    assign src1_plus_imm = src1 + imm;

    // write-back value
    always_comb begin
        case (alu_op)
            ALU_LUI:   result = imm;
            ALU_AUIPC: result = pc_plus_imm;
            // link value for both jumps
            ALU_JAL:   result = pc_plus_4;
            ALU_JALR:  result = pc_plus_4;
            ALU_ADDI:  result = src1_plus_imm;
            ALU_ADD:   result = src1 + src2;
            // nop and ebreak write nothing
            default:   result = '0;
        endcase
    end

    // next pc, sequential unless a jump
    always_comb begin
        case (alu_op)
            ALU_JAL:  next_pc = pc_plus_imm;
            // jalr target has bit 0 cleared
            ALU_JALR: next_pc = {src1_plus_imm[31:1], 1'b0};
            default:  next_pc = pc_plus_4;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/npc_top.sv
`timescale 1ns/1ps
`default_nettype none

module npc_top import npc_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       load_en,
    input  imem_addr_t load_addr,
    input  word_t      load_data,
    input  logic       run,
    output word_t      pc,
    output logic       halted,
    output logic       retire_valid,
    output word_t      retire_pc,
    output logic       retire_wen,
    output reg_addr_t  retire_rd,
    output word_t      retire_data
);

    word_t     instr;
    word_t     next_pc;
    word_t     imm;
    word_t     src1;
    word_t     src2;
    word_t     result;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    alu_op_t   alu_op;
    logic      reg_wen;
    logic      advance;

    // fetch, pc and halt
    instr_fetch instr_fetch_inst (
        .clk       (clk),
        .reset     (reset),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .run       (run),
        .next_pc   (next_pc),
        .alu_op    (alu_op),
        .pc        (pc),
        .instr     (instr),
        .halted    (halted),
        .advance   (advance)
    );

    inst_decode inst_decode_inst (
        .instr   (instr),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .imm     (imm),
        .alu_op  (alu_op),
        .reg_wen (reg_wen)
    );

    // writes land together with the pc update
    reg_file reg_file_inst (
        .clk     (clk),
        .advance (advance),
        .wen     (reg_wen),
        .waddr   (rd),
        .wdata   (result),
        .raddr1  (rs1),
        .raddr2  (rs2),
        .rdata1  (src1),
        .rdata2  (src2)
    );

    exec_alu exec_alu_inst (
        .alu_op  (alu_op),
        .pc      (pc),
        .imm     (imm),
        .src1    (src1),
        .src2    (src2),
        .result  (result),
        .next_pc (next_pc)
    );

    // retire port describes the instruction at pc this cycle
    assign retire_valid = advance;
    assign retire_pc    = pc;
    assign retire_wen   = reg_wen;
    assign retire_rd    = rd;
    assign retire_data  = result;

endmodule

`default_nettype wire

//--- verif/npc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module npc_tb import npc_pkg::*; ();

    // cycles allowed per program before giving up on halt
    localparam int TIMEOUT = 1000;
    // word index of the closing ebreak
    localparam int BODY_END = 61;

    logic       clk;
    logic       reset;
    logic       load_en;
    imem_addr_t load_addr;
    word_t      load_data;
    logic       run;
    word_t      pc;
    logic       halted;
    logic       retire_valid;
    word_t      retire_pc;
    logic       retire_wen;
    reg_addr_t  retire_rd;
    word_t      retire_data;

    // reference model state
    word_t prog [IMEM_DEPTH];
    word_t mregs [32];
    word_t mpc;
    logic  mhalt;
    string test_name;

    always #4 clk = ~clk;

    npc_top npc_top_inst (
        .clk          (clk),
        .reset        (reset),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .run          (run),
        .pc           (pc),
        .halted       (halted),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_wen   (retire_wen),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    // instruction encoders
    function automatic word_t enc_i(logic [6:0] opc, reg_addr_t rd, logic [2:0] f3,
                                    reg_addr_t rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_u(logic [6:0] opc, reg_addr_t rd, logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    // j format scrambles the offset bits
    function automatic word_t enc_j(reg_addr_t rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic word_t enc_r(reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
        return {7'b0000000, rs2, rs1, 3'b000, rd, OPC_OP};
    endfunction

    task automatic check_word(string what, word_t exp, word_t got);
        assert (got == exp) else begin
            $display("FAILED %s: %s expected %h actual %h", test_name, what, exp, got);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    // preamble loads x1..x31, body jumps only forward so every program ends
    task automatic build_program();
        logic [31:0] r;
        logic [31:0] off;
        int          t;
        for (int i = 1; i < 32; i++) begin
            r = $urandom;
            prog[i-1] = enc_i(OPC_OP_IMM, reg_addr_t'(i), 3'b000, 5'd0, r[11:0]);
        end
        for (int k = 31; k < IMEM_DEPTH; k++) begin
            prog[k] = INST_EBREAK;
        end
        for (int k = 31; k < BODY_END; k++) begin
            r = $urandom;
            // jump target somewhere after k, at most the ebreak
            t = k + 1 + int'($urandom % (BODY_END - k));
            case ($urandom % 7)
                0: prog[k] = enc_u(OPC_LUI, r[11:7], r[31:12]);
                1: prog[k] = enc_u(OPC_AUIPC, r[11:7], r[31:12]);
                2: begin
                    // +-256 bytes lands on the same word, pc leaves the window
                    off = 32'((t - k) * 4 + 256 * (int'($urandom % 3) - 1));
                    prog[k] = enc_j(r[11:7], off[20:0]);
                end
                3: begin
                    // base x0, bit 0 set at random to see it cleared
                    off = 32'(t * 4 + 256 * int'(r[31:30])) | 32'(r[0]);
                    prog[k] = enc_i(OPC_JALR, r[11:7], 3'b000, 5'd0, off[11:0]);
                end
                4: prog[k] = enc_i(OPC_OP_IMM, r[11:7], 3'b000, r[19:15], r[31:20]);
                5: prog[k] = enc_r(r[11:7], r[19:15], r[24:20]);
                // addi opcode with a nonzero funct3, outside the subset
                default: prog[k] = enc_i(OPC_OP_IMM, r[11:7],
                                         (r[14:12] == 3'd0) ? 3'd1 : r[14:12],
                                         r[19:15], r[31:20]);
            endcase
        end
    endtask

    // one model cycle, sampled at the falling edge
    task automatic step_check();
        word_t w;
        word_t iimm;
        word_t uimm;
        word_t jimm;
        word_t exp_data;
        word_t exp_next;
        logic  exp_wen;
        logic  is_brk;
        w    = prog[mpc[7:2]];
        iimm = {{20{w[31]}}, w[31:20]};
        uimm = {w[31:12], 12'h000};
        jimm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        check_word("halted", 32'(mhalt), 32'(halted));
        check_word("pc", mpc, pc);
        if (!run || mhalt) begin
            check_word("retire_valid", 32'd0, 32'(retire_valid));
        end else begin
            is_brk   = (w == INST_EBREAK);
            exp_wen  = 1'b1;
            exp_data = '0;
            exp_next = mpc + 32'd4;
            case (w[6:0])
                OPC_LUI:   exp_data = uimm;
                OPC_AUIPC: exp_data = mpc + uimm;
                OPC_JAL: begin
                    exp_data = mpc + 32'd4;
                    exp_next = mpc + jimm;
                end
                OPC_JALR: begin
                    exp_wen  = (w[14:12] == 3'd0);
                    exp_data = mpc + 32'd4;
                    if (exp_wen) exp_next = (mregs[w[19:15]] + iimm) & ~32'd1;
                end
                OPC_OP_IMM: begin
                    exp_wen  = (w[14:12] == 3'd0);
                    exp_data = mregs[w[19:15]] + iimm;
                end
                OPC_OP: begin
                    exp_wen  = (w[14:12] == 3'd0) && (w[31:25] == 7'd0);
                    exp_data = mregs[w[19:15]] + mregs[w[24:20]];
                end
                // ebreak and unknown opcodes write nothing
                default: exp_wen = 1'b0;
            endcase
            check_word("retire_valid", 32'd1, 32'(retire_valid));
            check_word("retire_pc", mpc, retire_pc);
            check_word("retire_wen", 32'(exp_wen), 32'(retire_wen));
            check_word("retire_rd", 32'(w[11:7]), 32'(retire_rd));
            if (exp_wen) check_word("retire_data", exp_data, retire_data);
            // x0 stays zero in the model
            if (exp_wen && w[11:7] != 5'd0) mregs[w[11:7]] = exp_data;
            if (is_brk) mhalt = 1'b1;
            else mpc = exp_next;
        end
    endtask

    task automatic run_program(string name);
        int cycles;
        int after_halt;
        test_name = name;
        build_program();
        @(posedge clk);
        reset   <= 1'b1;
        run     <= 1'b0;
        load_en <= 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        // one word per clock, core stopped
        for (int a = 0; a < IMEM_DEPTH; a++) begin
            load_en   <= 1'b1;
            load_addr <= imem_addr_t'(a);
            load_data <= prog[a];
            @(posedge clk);
        end
        load_en <= 1'b0;
        mpc   = RESET_PC;
        mhalt = 1'b0;
        for (int i = 0; i < 32; i++) mregs[i] = '0;
        cycles     = 0;
        after_halt = 0;
        // keep run high for a few cycles past the halt
        while (after_halt < 4) begin
            if (cycles == TIMEOUT) begin
                $display("timeout: %s did not halt within %0d cycles", name, TIMEOUT);
                $display("TB FAILED");
                $fatal(1);
            end
            @(posedge clk);
            run <= mhalt || ($urandom % 4 != 0);
            @(negedge clk);
            step_check();
            if (mhalt) after_halt++;
            cycles++;
        end
        @(posedge clk);
        run <= 1'b0;
    endtask

    initial begin
        int unsigned seed_val;
        clk       = 1'b0;
        reset     = 1'b1;
        run       = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        seed_val  = $urandom(32'hd870205a);
        run_program("prog_a");
        run_program("prog_b");
        run_program("prog_c");
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
hw/npc_pkg.sv
hw/instr_fetch.sv
hw/reg_file.sv
hw/inst_decode.sv
hw/exec_alu.sv
hw/npc_top.sv
verif/npc_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with verilator and run the npc testbench

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sources.f --top-module npc_tb -o npc_sim; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/npc_sim 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TB PASSED"; then
    exit 0
else
    echo "pass message not found in simulation output"
    exit 1
fi
